//--- project.f
+incdir+src
src/cpu_isa_pkg.sv
src/cpu_bus_pkg.sv
src/instr_sequencer.sv
src/decode_rom.sv
src/cpu_datapath.sv
src/bus_interface.sv
src/cpu_top.sv
tests/cpu_tb.sv

//--- tests/cpu_tb.sv
// Testbench for the 6502-style core with a 64K memory model and a reference model.
// Runs the reset sequence, directed programs and one random program,
// and compares every bus cycle with the model.
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb
    import cpu_isa_pkg::*, cpu_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int RANDOM_INSTR = 200;
    localparam int NUM_TESTS    = 5;
    localparam int TOTAL_INSTR  = 2 + 2 + 8 + RANDOM_INSTR;
    // at most 4 cycles per instruction plus reset and sequence overhead per test
    localparam int TEST_CYCLES  = NUM_TESTS * 16 + 4 * TOTAL_INSTR;
    localparam int MARGIN       = 200;
    localparam logic [31:0] SEED = 32'd96029;

    logic     i_clk;
    logic     i_reset;
    data_t    i_data;
    addr_t    o_addr;
    data_t    o_data;
    bus_dir_t o_rw;
    logic     o_sync;

    data_t mem [0:65535];
    data_t ref_mem [0:65535];

    // reference model state
    data_t model_ir;
    int    model_t;
    addr_t model_pc;
    data_t model_s;
    data_t model_a;
    data_t model_lo;
    data_t model_hi;
    int    model_fetches;

    logic [31:0] rng_state;
    logic [25:0] expected;
    string       test_name;
    logic        checking;
    addr_t       prog_ptr;
    addr_t       prog_base;

    // what the comparing process saw on the bus
    logic  seen_sync;
    addr_t first_fetch;
    addr_t last_fetch;
    int    cycle_count;
    int    sync_latency;

    cpu_top dut (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  (i_data),
        .o_addr  (o_addr),
        .o_data  (o_data),
        .o_rw    (o_rw),
        .o_sync  (o_sync)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // memory answers in the same cycle
    assign i_data = mem[o_addr];

    always @(posedge i_clk)
    begin
        if (o_rw == BUS_WRITE)
            mem[o_addr] <= o_data;
    end

    task automatic check_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val)
        begin
            $display("Error: %s expected %0h actual %0h", what, exp_val, act_val);
            $display("Done: errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // program start well clear of the data region
    function automatic addr_t random_base();
        logic [31:0] r;
        r = next_rand();
        return 16'h0200 + {4'h0, r[11:0]};
    endfunction

    // operands live in 0x4000 to 0x7FFF
    function automatic addr_t data_addr();
        logic [31:0] r;
        r = next_rand();
        return {2'b01, r[13:0]};
    endfunction

    function automatic data_t pick_unknown();
        data_t op;
        op = data_t'(next_rand() >> 8);
        while (op == BRK || op == NOP || op == LDA_IMM || op == LDA_ABS || op == STA_ABS)
            op = data_t'(next_rand() >> 8);
        return op;
    endfunction

    task automatic fill_memory();
        int a;
        for (a = 0; a < 65536; a++)
        begin
            mem[a]     = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3C;
            ref_mem[a] = mem[a];
        end
    endtask

    task automatic put_byte(input addr_t addr, input data_t value);
        mem[addr]     = value;
        ref_mem[addr] = value;
    endtask

    task automatic emit_byte(input data_t value);
        put_byte(prog_ptr, value);
        prog_ptr = prog_ptr + 16'd1;
    endtask

    task automatic emit_abs(input data_t op, input addr_t addr);
        emit_byte(op);
        emit_byte(addr[7:0]);
        emit_byte(addr[15:8]);
    endtask

    task automatic reset_model();
        // reset enters BRK at T1 with PC cleared
        model_ir      = BRK;
        model_t       = 1;
        model_pc      = 16'h0000;
        model_s       = `CPU_RESET_SP;
        model_a       = 8'h00;
        model_lo      = 8'h00;
        model_hi      = 8'h00;
        model_fetches = 0;
    endtask

    // one bus cycle of the model as {sync, rw, addr, write data}
    function automatic logic [25:0] step_model();
        addr_t addr;
        logic  rd;
        data_t wdata;
        logic  sync;
        addr  = model_pc;
        rd    = 1'b1;
        wdata = 8'h00;
        sync  = (model_t == 0);
        case (model_t)
            0:
            begin
                model_ir      = ref_mem[model_pc];
                model_pc      = model_pc + 16'd1;
                model_fetches = model_fetches + 1;
                model_t       = 1;
            end
            1:
            begin
                case (model_ir)
                    BRK:
                    begin
                        model_t = 2;
                    end
                    LDA_IMM:
                    begin
                        model_a  = ref_mem[model_pc];
                        model_pc = model_pc + 16'd1;
                        model_t  = 0;
                    end
                    LDA_ABS, STA_ABS:
                    begin
                        model_lo = ref_mem[model_pc];
                        model_pc = model_pc + 16'd1;
                        model_t  = 2;
                    end
                    default:
                    begin
                        model_t = 0;
                    end
                endcase
            end
            2:
            begin
                if (model_ir == BRK)
                begin
                    addr = {`CPU_STACK_PAGE, model_s};
                end
                else
                begin
                    model_hi = ref_mem[model_pc];
                    model_pc = model_pc + 16'd1;
                end
                model_t = 3;
            end
            3:
            begin
                if (model_ir == BRK)
                begin
                    addr    = {`CPU_STACK_PAGE, data_t'(model_s - 8'd1)};
                    model_t = 4;
                end
                else
                begin
                    addr = {model_hi, model_lo};
                    if (model_ir == STA_ABS)
                    begin
                        rd            = 1'b0;
                        wdata         = model_a;
                        ref_mem[addr] = model_a;
                    end
                    else
                    begin
                        model_a = ref_mem[addr];
                    end
                    model_t = 0;
                end
            end
            4:
            begin
                addr    = {`CPU_STACK_PAGE, data_t'(model_s - 8'd2)};
                model_s = model_s - 8'd3;
                model_t = 5;
            end
            5:
            begin
                addr     = `CPU_RESET_VECTOR;
                model_lo = ref_mem[addr];
                model_t  = 6;
            end
            default:
            begin
                // PC takes the vector with its high byte
                addr     = `CPU_RESET_VECTOR + 16'd1;
                model_hi = ref_mem[addr];
                model_pc = {model_hi, model_lo};
                model_t  = 0;
            end
        endcase
        return {sync, rd, addr, wdata};
    endfunction

    // compares the bus with the model on every rising edge
    always @(posedge i_clk)
    begin
        if (checking)
        begin
            expected = step_model();
            check_value({test_name, " o_sync"}, expected[25], o_sync);
            check_value({test_name, " o_rw"}, expected[24], o_rw);
            check_value({test_name, " o_addr"}, expected[23:8], o_addr);
            if (expected[24] == BUS_WRITE)
                check_value({test_name, " o_data"}, expected[7:0], o_data);
            if (o_sync)
            begin
                if (!seen_sync)
                begin
                    seen_sync    = 1'b1;
                    first_fetch  = o_addr;
                    sync_latency = cycle_count;
                end
                last_fetch = o_addr;
            end
            cycle_count = cycle_count + 1;
        end
    end

    task automatic start_test(input string name, input addr_t base);
        @(negedge i_clk);
        checking  = 1'b0;
        i_reset   = 1'b1;
        test_name = name;
        // let one reset edge pass so no stray write lands after the reload
        @(negedge i_clk);
        fill_memory();
        prog_base = base;
        prog_ptr  = base;
    endtask

    task automatic run_test(input int n_instr);
        put_byte(`CPU_RESET_VECTOR, prog_base[7:0]);
        put_byte(`CPU_RESET_VECTOR + 16'd1, prog_base[15:8]);
        repeat (RESET_CYCLES - 1) @(negedge i_clk);
        reset_model();
        seen_sync   = 1'b0;
        cycle_count = 0;
        i_reset     = 1'b0;
        checking    = 1'b1;
        // run up to the fetch that follows the last instruction
        while (model_fetches <= n_instr)
            @(negedge i_clk);
        checking = 1'b0;
    endtask

    initial
    begin
        addr_t base;
        addr_t src;
        addr_t dst;
        data_t value;
        int    i;
        int    kind;

        i_reset      = 1'b1;
        checking     = 1'b0;
        rng_state    = SEED;
        test_name    = "idle";
        seen_sync    = 1'b0;
        cycle_count  = 0;
        sync_latency = 0;
        first_fetch  = 16'h0000;
        last_fetch   = 16'h0000;
        prog_ptr     = 16'h0000;
        prog_base    = 16'h0000;
        reset_model();
        fill_memory();

        // reset sequence into a random vector
        base = random_base();
        start_test("reset", base);
        run_test(0);
        check_value("reset first fetch", base, first_fetch);
        check_value("reset latency", 6, sync_latency);

        // immediate byte stored to memory
        base  = random_base();
        value = data_t'(next_rand() >> 8);
        dst   = data_addr();
        start_test("lda_imm_sta", base);
        emit_byte(LDA_IMM);
        emit_byte(value);
        emit_abs(STA_ABS, dst);
        run_test(2);
        check_value("lda_imm_sta stored byte", value, mem[dst]);

        // copy one byte between two random addresses
        base  = random_base();
        value = data_t'(next_rand() >> 8);
        src   = data_addr();
        dst   = data_addr();
        while (dst == src)
            dst = data_addr();
        start_test("lda_abs_sta", base);
        put_byte(src, value);
        emit_abs(LDA_ABS, src);
        emit_abs(STA_ABS, dst);
        run_test(2);
        check_value("lda_abs_sta copied byte", value, mem[dst]);

        // two-cycle opcodes step PC by one
        base = random_base();
        start_test("nop_unknown", base);
        for (i = 0; i < 8; i++)
        begin
            if (i % 3 == 0)
                emit_byte(NOP);
            else
                emit_byte(pick_unknown());
        end
        run_test(8);
        check_value("nop_unknown final fetch", base + 16'd8, last_fetch);

        // random program without BRK since it restarts at the vector
        base = random_base();
        start_test("random", base);
        for (i = 0; i < RANDOM_INSTR; i++)
        begin
            kind = int'(next_rand() % 5);
            case (kind)
                0: emit_byte(NOP);
                1:
                begin
                    emit_byte(LDA_IMM);
                    emit_byte(data_t'(next_rand() >> 8));
                end
                2: emit_abs(LDA_ABS, data_addr());
                3: emit_abs(STA_ABS, data_addr());
                default: emit_byte(pick_unknown());
            endcase
        end
        run_test(RANDOM_INSTR);
        check_value("random final fetch", prog_ptr, last_fetch);

        $display("Done: no errors");
        $finish;
    end

    initial
    begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
        $display("Error: watchdog expired, the tests did not finish in time");
        $display("Done: errors found");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- src/cpu_top.sv
// Top level of the 6502-style core.
// Memory is external and answers i_data in the same cycle as o_addr.
`timescale 1ns/1ns

module cpu_top
    import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  data_t    i_data,
    output addr_t    o_addr,
    output data_t    o_data,
    output bus_dir_t o_rw,
    output logic     o_sync
);

    opcode_t  ir;
    tcu_t     tcu;
    tcu_t     tcu_next;
    bus_dir_t rw;
    data_t    adl;
    data_t    adh;
    data_t    db;

    // control lines from the decode ROM
    logic ctl_dl_db, ctl_dl_adh;
    logic ctl_pcl_adl, ctl_pch_adh, ctl_adl_pcl, ctl_adh_pch, ctl_i_pc;
    logic ctl_ac_db, ctl_sb_ac, ctl_s_adl, ctl_sb_s;
    logic ctl_add_adl, ctl_add_sb, ctl_db_add, ctl_adl_add;
    logic ctl_0_add, ctl_db_n_add, ctl_sb_add, ctl_sums;
    logic ctl_vec_adl, ctl_vec_hi, ctl_stack_adh;
    logic ctl_adl_abl, ctl_adh_abh;

    instr_sequencer u_sequencer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_data     (i_data),
        .i_tcu_next (tcu_next),
        .o_ir       (ir),
        .o_tcu      (tcu),
        .o_sync     (o_sync)
    );

    decode_rom u_decode (
        .i_ir        (ir),
        .i_tcu       (tcu),
        .o_tcu_next  (tcu_next),
        .o_rw        (rw),
        .o_dl_db     (ctl_dl_db),
        .o_dl_adh    (ctl_dl_adh),
        .o_pcl_adl   (ctl_pcl_adl),
        .o_pch_adh   (ctl_pch_adh),
        .o_adl_pcl   (ctl_adl_pcl),
        .o_adh_pch   (ctl_adh_pch),
        .o_i_pc      (ctl_i_pc),
        .o_ac_db     (ctl_ac_db),
        .o_sb_ac     (ctl_sb_ac),
        .o_s_adl     (ctl_s_adl),
        .o_sb_s      (ctl_sb_s),
        .o_add_adl   (ctl_add_adl),
        .o_add_sb    (ctl_add_sb),
        .o_db_add    (ctl_db_add),
        .o_adl_add   (ctl_adl_add),
        .o_0_add     (ctl_0_add),
        .o_db_n_add  (ctl_db_n_add),
        .o_sb_add    (ctl_sb_add),
        .o_sums      (ctl_sums),
        .o_vec_adl   (ctl_vec_adl),
        .o_vec_hi    (ctl_vec_hi),
        .o_stack_adh (ctl_stack_adh),
        .o_adl_abl   (ctl_adl_abl),
        .o_adh_abh   (ctl_adh_abh)
    );

    cpu_datapath u_datapath (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_data      (i_data),
        .i_dl_db     (ctl_dl_db),
        .i_dl_adh    (ctl_dl_adh),
        .i_pcl_adl   (ctl_pcl_adl),
        .i_pch_adh   (ctl_pch_adh),
        .i_adl_pcl   (ctl_adl_pcl),
        .i_adh_pch   (ctl_adh_pch),
        .i_i_pc      (ctl_i_pc),
        .i_ac_db     (ctl_ac_db),
        .i_sb_ac     (ctl_sb_ac),
        .i_s_adl     (ctl_s_adl),
        .i_sb_s      (ctl_sb_s),
        .i_add_adl   (ctl_add_adl),
        .i_add_sb    (ctl_add_sb),
        .i_db_add    (ctl_db_add),
        .i_adl_add   (ctl_adl_add),
        .i_0_add     (ctl_0_add),
        .i_db_n_add  (ctl_db_n_add),
        .i_sb_add    (ctl_sb_add),
        .i_sums      (ctl_sums),
        .i_vec_adl   (ctl_vec_adl),
        .i_vec_hi    (ctl_vec_hi),
        .i_stack_adh (ctl_stack_adh),
        .o_adl       (adl),
        .o_adh       (adh),
        .o_db        (db)
    );

    bus_interface u_bus (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_adl     (adl),
        .i_adh     (adh),
        .i_db      (db),
        .i_adl_abl (ctl_adl_abl),
        .i_adh_abh (ctl_adh_abh),
        .i_rw      (rw),
        .o_addr    (o_addr),
        .o_data    (o_data),
        .o_rw      (o_rw)
    );

endmodule

//--- src/bus_interface.sv
// Address bus latch, data output and read/write strobe toward memory.
// Each address half follows its internal bus only while loaded.
`timescale 1ns/1ns

module bus_interface
    import cpu_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  data_t    i_adl,
    input  data_t    i_adh,
    input  data_t    i_db,
    input  logic     i_adl_abl,
    input  logic     i_adh_abh,
    input  bus_dir_t i_rw,
    output addr_t    o_addr,
    output data_t    o_data,
    output bus_dir_t o_rw
);

    data_t abl_q;
    data_t abh_q;
    data_t abl;
    data_t abh;

    // pass while loaded, otherwise last cycle's value
    assign abl = i_adl_abl ? i_adl : abl_q;
    assign abh = i_adh_abh ? i_adh : abh_q;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            abl_q <= 8'h00;
            abh_q <= 8'h00;
        end
        else
        begin
            abl_q <= abl;
            abh_q <= abh;
        end
    end

    assign o_addr = {abh, abl};
    assign o_data = i_db;
    assign o_rw   = i_rw;

endmodule

//--- src/cpu_datapath.sv
// Register file and internal buses of the core: PC, S, A, adder and data latch.
// Forms ADL, ADH, SB and DB each cycle from the decode ROM's source selects.
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_datapath
    import cpu_bus_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset,
    input  data_t i_data,
    input  logic  i_dl_db,
    input  logic  i_dl_adh,
    input  logic  i_pcl_adl,
    input  logic  i_pch_adh,
    input  logic  i_adl_pcl,
    input  logic  i_adh_pch,
    input  logic  i_i_pc,
    input  logic  i_ac_db,
    input  logic  i_sb_ac,
    input  logic  i_s_adl,
    input  logic  i_sb_s,
    input  logic  i_add_adl,
    input  logic  i_add_sb,
    input  logic  i_db_add,
    input  logic  i_adl_add,
    input  logic  i_0_add,
    input  logic  i_db_n_add,
    input  logic  i_sb_add,
    input  logic  i_sums,
    input  logic  i_vec_adl,
    input  logic  i_vec_hi,
    input  logic  i_stack_adh,
    output data_t o_adl,
    output data_t o_adh,
    output data_t o_db
);

    data_t pcl_q;
    data_t pch_q;
    data_t s_q;
    data_t ac_q;
    data_t add_q;
    data_t dl_q;
    data_t adl_bus;
    data_t adh_bus;
    data_t db_bus;
    data_t sb_bus;
    data_t add_a;
    data_t add_b;
    data_t add_sum;
    data_t pcl_src;
    data_t pch_src;
    addr_t vec_addr;
    logic [8:0] pcl_inc;

    assign vec_addr = `CPU_RESET_VECTOR + addr_t'(i_vec_hi);

    // undriven buses read all ones
    always_comb
    begin
        db_bus = 8'hFF;
        if (i_dl_db)
            db_bus = i_data;
        else if (i_ac_db)
            db_bus = ac_q;

        adl_bus = 8'hFF;
        if (i_pcl_adl)
            adl_bus = pcl_q;
        else if (i_s_adl)
            adl_bus = s_q;
        else if (i_add_adl)
            adl_bus = add_q;
        else if (i_vec_adl)
            adl_bus = vec_addr[7:0];

        // dl_adh uses the byte held from the previous cycle
        adh_bus = 8'hFF;
        if (i_pch_adh)
            adh_bus = pch_q;
        else if (i_dl_adh)
            adh_bus = dl_q;
        else if (i_stack_adh)
            adh_bus = `CPU_STACK_PAGE;
        else if (i_vec_adl)
            adh_bus = vec_addr[15:8];
    end

    // adder reads SB as DB presents it, never its own result
    always_comb
    begin
        add_a = 8'hFF;
        if (i_0_add)
            add_a = 8'h00;
        else if (i_sb_add)
            add_a = db_bus;

        add_b = 8'hFF;
        if (i_db_add)
            add_b = db_bus;
        else if (i_db_n_add)
            add_b = ~db_bus;
        else if (i_adl_add)
            add_b = adl_bus;
    end

    // carry in with the inverted input makes a true subtract
    assign add_sum = add_a + add_b + data_t'(i_db_n_add);

    // SB is shorted to DB unless the adder drives it
    assign sb_bus = i_add_sb ? add_sum : db_bus;

    // PC incrementer, loads from ADL/ADH before counting
    assign pcl_src = i_adl_pcl ? adl_bus : pcl_q;
    assign pch_src = i_adh_pch ? adh_bus : pch_q;
    assign pcl_inc = {1'b0, pcl_src} + 9'(i_i_pc);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            pcl_q <= 8'h00;
            pch_q <= 8'h00;
            s_q   <= `CPU_RESET_SP;
            ac_q  <= 8'h00;
        end
        else
        begin
            pcl_q <= pcl_inc[7:0];
            pch_q <= pch_src + data_t'(pcl_inc[8]);
            if (i_sb_s)
                s_q <= sb_bus;
            if (i_sb_ac)
                ac_q <= sb_bus;
        end
    end

    // held sum carries address bytes and stack steps across T-states
    always_ff @(posedge i_clk)
    begin
        if (i_sums)
            add_q <= add_sum;
        dl_q <= i_data;
    end

    assign o_adl = adl_bus;
    assign o_adh = adh_bus;
    assign o_db  = db_bus;

endmodule

//--- src/decode_rom.sv
// Decode ROM: maps instruction register and timing state to control lines.
// Purely combinational; also picks the next timing state for the sequencer.
`timescale 1ns/1ns

module decode_rom
    import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
    input  opcode_t  i_ir,
    input  tcu_t     i_tcu,
    output tcu_t     o_tcu_next,
    output bus_dir_t o_rw,
    output logic     o_dl_db,
    output logic     o_dl_adh,
    output logic     o_pcl_adl,
    output logic     o_pch_adh,
    output logic     o_adl_pcl,
    output logic     o_adh_pch,
    output logic     o_i_pc,
    output logic     o_ac_db,
    output logic     o_sb_ac,
    output logic     o_s_adl,
    output logic     o_sb_s,
    output logic     o_add_adl,
    output logic     o_add_sb,
    output logic     o_db_add,
    output logic     o_adl_add,
    output logic     o_0_add,
    output logic     o_db_n_add,
    output logic     o_sb_add,
    output logic     o_sums,
    output logic     o_vec_adl,
    output logic     o_vec_hi,
    output logic     o_stack_adh,
    output logic     o_adl_abl,
    output logic     o_adh_abh
);

    always_comb
    begin
        o_tcu_next  = tcu_t'(i_tcu + 3'd1);
        o_rw        = BUS_READ;
        o_dl_db     = 1'b0;
        o_dl_adh    = 1'b0;
        o_pcl_adl   = 1'b0;
        o_pch_adh   = 1'b0;
        o_adl_pcl   = 1'b0;
        o_adh_pch   = 1'b0;
        o_i_pc      = 1'b0;
        o_ac_db     = 1'b0;
        o_sb_ac     = 1'b0;
        o_s_adl     = 1'b0;
        o_sb_s      = 1'b0;
        o_add_adl   = 1'b0;
        o_add_sb    = 1'b0;
        o_db_add    = 1'b0;
        o_adl_add   = 1'b0;
        o_0_add     = 1'b0;
        o_db_n_add  = 1'b0;
        o_sb_add    = 1'b0;
        o_sums      = 1'b0;
        o_vec_adl   = 1'b0;
        o_vec_hi    = 1'b0;
        o_stack_adh = 1'b0;
        // both address halves load unless a cycle keeps its page
        o_adl_abl   = 1'b1;
        o_adh_abh   = 1'b1;

        case (i_tcu)
            T0:
            begin
                o_i_pc = 1'b1;
                if (i_ir == BRK)
                begin
                    // fetch from the vector just read and load it into PC
                    o_add_adl = 1'b1;
                    o_dl_adh  = 1'b1;
                    o_adl_pcl = 1'b1;
                    o_adh_pch = 1'b1;
                end
                else
                begin
                    o_pcl_adl = 1'b1;
                    o_pch_adh = 1'b1;
                end
            end
            T1:
            begin
                o_pcl_adl = 1'b1;
                o_pch_adh = 1'b1;
                case (i_ir)
                    BRK:
                    begin
                        // dummy read at PC without increment
                    end
                    LDA_IMM:
                    begin
                        o_i_pc     = 1'b1;
                        o_dl_db    = 1'b1;
                        o_sb_ac    = 1'b1;
                        o_tcu_next = T0;
                    end
                    LDA_ABS, STA_ABS:
                    begin
                        // low address byte into the adder hold
                        o_i_pc   = 1'b1;
                        o_dl_db  = 1'b1;
                        o_db_add = 1'b1;
                        o_0_add  = 1'b1;
                        o_sums   = 1'b1;
                    end
                    default:
                    begin
                        o_tcu_next = T0;
                    end
                endcase
            end
            T2:
            begin
                if (i_ir == BRK)
                begin
                    // address 0x0100 + S while the adder forms S - 1
                    o_s_adl     = 1'b1;
                    o_stack_adh = 1'b1;
                    o_sb_add    = 1'b1;
                    o_adl_add   = 1'b1;
                    o_sums      = 1'b1;
                end
                else
                begin
                    // high address byte caught by the data latch
                    o_pcl_adl = 1'b1;
                    o_pch_adh = 1'b1;
                    o_i_pc    = 1'b1;
                end
            end
            T3:
            begin
                o_add_adl = 1'b1;
                if (i_ir == BRK)
                begin
                    // stack page stays latched from T2
                    o_adh_abh = 1'b0;
                    o_sb_add  = 1'b1;
                    o_adl_add = 1'b1;
                    o_sums    = 1'b1;
                end
                else
                begin
                    // effective address from adder hold and latch
                    o_dl_adh   = 1'b1;
                    o_tcu_next = T0;
                    if (i_ir == STA_ABS)
                    begin
                        o_ac_db = 1'b1;
                        o_rw    = BUS_WRITE;
                    end
                    else
                    begin
                        o_dl_db = 1'b1;
                        o_sb_ac = 1'b1;
                    end
                end
            end
            T4:
            begin
                // last stack address while S takes S - 3 off the live sum
                o_add_adl = 1'b1;
                o_adh_abh = 1'b0;
                o_sb_add  = 1'b1;
                o_adl_add = 1'b1;
                o_add_sb  = 1'b1;
                o_sb_s    = 1'b1;
            end
            T5:
            begin
                // vector low byte kept in the adder hold
                o_vec_adl = 1'b1;
                o_dl_db   = 1'b1;
                o_db_add  = 1'b1;
                o_0_add   = 1'b1;
                o_sums    = 1'b1;
            end
            T6:
            begin
                // vector high byte caught by the data latch
                // vector page stays latched from T5
                o_vec_adl  = 1'b1;
                o_vec_hi   = 1'b1;
                o_adh_abh  = 1'b0;
                o_tcu_next = T0;
            end
            default:
            begin
                o_tcu_next = T0;
            end
        endcase
    end

endmodule

//--- src/instr_sequencer.sv
// Instruction register and timing-state counter.
// Feeds the decode ROM and takes back the next timing state it picks.
`timescale 1ns/1ns

module instr_sequencer
    import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  data_t   i_data,
    input  tcu_t    i_tcu_next,
    output opcode_t o_ir,
    output tcu_t    o_tcu,
    output logic    o_sync
);

    opcode_t ir_q;
    tcu_t    tcu_q;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            // reset runs as BRK, entering past the fetch
            ir_q  <= BRK;
            tcu_q <= T1;
        end
        else
        begin
            // opcode arrives with the fetch cycle
            if (tcu_q == T0)
            begin
                ir_q <= opcode_t'(i_data);
            end
            tcu_q <= i_tcu_next;
        end
    end

    assign o_ir   = ir_q;
    assign o_tcu  = tcu_q;

    // marks the opcode fetch cycle
    assign o_sync = (tcu_q == T0);

endmodule

//--- src/cpu_bus_pkg.sv
// Memory bus types of the 6502-style core.
// Shared by the datapath, the bus interface and the top level.
package cpu_bus_pkg;

    // 16-bit address bus
    typedef logic [15:0] addr_t;

    // 8-bit data byte
    typedef logic [7:0] data_t;

    // read/write strobe, high for a read as on the 6502
    typedef enum logic {
        BUS_WRITE = 1'b0,
        BUS_READ  = 1'b1
    } bus_dir_t;

endpackage

//--- src/cpu_isa_pkg.sv
// Instruction set types of the 6502-style core.
// Shared by the sequencer, the decode ROM and the testbench.
package cpu_isa_pkg;

    // supported opcodes, any other value runs as a two-cycle no-op
    typedef enum logic [7:0] {
        BRK     = 8'h00,
        NOP     = 8'hEA,
        LDA_IMM = 8'hA9,
        LDA_ABS = 8'hAD,
        STA_ABS = 8'h8D
    } opcode_t;

    // timing state, one per clock
    typedef enum logic [2:0] {
        T0,
        T1,
        T2,
        T3,
        T4,
        T5,
        T6,
        T7
    } tcu_t;

endpackage

//--- src/cpu_cfg.svh
// Reset and stack constants for the 6502-style core.
// Include this where the vector or the stack page is formed.
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// low byte of the reset vector, high byte at the next address
`define CPU_RESET_VECTOR 16'hFFFC

// high address byte of the hardware stack
`define CPU_STACK_PAGE 8'h01

// stack pointer after reset, the reset sequence leaves 0xFD
`define CPU_RESET_SP 8'h00

`endif
